/* hw/csr_pkg.sv */
// Shared widths, CSR numbers, register indices, reset values and bus structs for the CSR file
`default_nettype none

package csr_pkg;

  typedef logic [31:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [63:0] csr_count_t;
  typedef logic [1:0]  csr_priv_t;
  typedef logic [1:0]  csr_op_t;
  typedef logic [4:0]  csr_index_t;

  // Privilege levels, 2 is reserved
  localparam csr_priv_t PRIV_U = 2'd0;
  localparam csr_priv_t PRIV_S = 2'd1;
  localparam csr_priv_t PRIV_M = 2'd3;

  localparam csr_op_t CSR_OP_NONE  = 2'd0;
  localparam csr_op_t CSR_OP_WRITE = 2'd1;
  localparam csr_op_t CSR_OP_SET   = 2'd2;
  localparam csr_op_t CSR_OP_CLEAR = 2'd3;

  // Internal register numbering
  localparam csr_index_t IDX_MSTATUS       = 5'd0;
  localparam csr_index_t IDX_MISA          = 5'd1;
  localparam csr_index_t IDX_MIE           = 5'd2;
  localparam csr_index_t IDX_MTVEC         = 5'd3;
  localparam csr_index_t IDX_MSCRATCH      = 5'd4;
  localparam csr_index_t IDX_MEPC          = 5'd5;
  localparam csr_index_t IDX_MCAUSE        = 5'd6;
  localparam csr_index_t IDX_MTVAL         = 5'd7;
  localparam csr_index_t IDX_MIP           = 5'd8;
  localparam csr_index_t IDX_MCOUNTEREN    = 5'd9;
  localparam csr_index_t IDX_MCOUNTINHIBIT = 5'd10;
  localparam csr_index_t IDX_MVENDORID     = 5'd11;
  localparam csr_index_t IDX_MARCHID       = 5'd12;
  localparam csr_index_t IDX_MIMPID        = 5'd13;
  localparam csr_index_t IDX_MHARTID       = 5'd14;
  // Counter halves sit in one aligned group of four
  localparam csr_index_t IDX_MCYCLE        = 5'd16;
  localparam csr_index_t IDX_MCYCLEH       = 5'd17;
  localparam csr_index_t IDX_MINSTRET      = 5'd18;
  localparam csr_index_t IDX_MINSTRETH     = 5'd19;
  localparam csr_index_t IDX_NONE          = 5'd31; // Unimplemented address

  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;

  localparam csr_data_t MSTATUS_WMASK    = 32'h0022_1888; // mie mpie mpp mprv tw
  localparam csr_data_t MIE_WMASK        = 32'h0000_0888; // Machine sw, timer, ext
  localparam csr_data_t MSTATUS_RESET    = 32'h0020_0000; // tw set, mpp = U
  localparam csr_data_t MCOUNTEREN_RESET = 32'hFFFF_FFFF;
  localparam csr_data_t MISA_VALUE       = 32'h4010_0100; // RV32, I and U

  // mcounteren / mcountinhibit bit positions
  localparam int unsigned CNT_CY = 0;
  localparam int unsigned CNT_TM = 1;
  localparam int unsigned CNT_IR = 2;

  typedef struct packed {
    csr_op_t   op;
    logic      read_only; // Instruction only reads
    logic      commit;    // Write may retire this cycle
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_data_t rdata;
    logic      invalid;
  } csr_rsp_t;

  typedef struct packed {
    logic       en;
    csr_index_t idx;
    csr_data_t  value; // Not yet legalized
  } csr_wr_t;

  typedef struct packed {
    csr_data_t mstatus;
    csr_data_t mie;
    csr_data_t mtvec;
    csr_data_t mscratch;
    csr_data_t mepc;
    csr_data_t mcause;
    csr_data_t mtval;
    csr_data_t mip;
    csr_data_t mcounteren;
    csr_data_t mcountinhibit;
  } csr_trap_state_t;

endpackage

`default_nettype wire

/* hw/csr_access_ctrl.sv */
// Combinational access control of the CSR file top level that decodes, checks and forms writes
`timescale 1ns/10ps
`default_nettype none

module csr_access_ctrl (
  input  csr_pkg::csr_req_t        req,
  input  csr_pkg::csr_priv_t       priv,
  input  csr_pkg::csr_data_t       old,
  input  csr_pkg::csr_trap_state_t state,
  output csr_pkg::csr_index_t      idx,
  output csr_pkg::csr_wr_t         wr,
  output logic                     invalid
);

  logic               op_active;
  logic               cy_alias;  // cycle / cycleh
  logic               ir_alias;  // instret / instreth
  logic               ro_fault;
  logic               priv_fault;
  logic               gate_fault;
  csr_pkg::csr_data_t new_value;

  assign op_active = req.op != csr_pkg::CSR_OP_NONE;

  // User counter aliases fold onto the machine halves
  always_comb begin
    cy_alias = 1'b0;
    ir_alias = 1'b0;
    case (req.addr)
      csr_pkg::MSTATUS_ADDR:       idx = csr_pkg::IDX_MSTATUS;
      csr_pkg::MISA_ADDR:          idx = csr_pkg::IDX_MISA;
      csr_pkg::MIE_ADDR:           idx = csr_pkg::IDX_MIE;
      csr_pkg::MTVEC_ADDR:         idx = csr_pkg::IDX_MTVEC;
      csr_pkg::MCOUNTEREN_ADDR:    idx = csr_pkg::IDX_MCOUNTEREN;
      csr_pkg::MCOUNTINHIBIT_ADDR: idx = csr_pkg::IDX_MCOUNTINHIBIT;
      csr_pkg::MSCRATCH_ADDR:      idx = csr_pkg::IDX_MSCRATCH;
      csr_pkg::MEPC_ADDR:          idx = csr_pkg::IDX_MEPC;
      csr_pkg::MCAUSE_ADDR:        idx = csr_pkg::IDX_MCAUSE;
      csr_pkg::MTVAL_ADDR:         idx = csr_pkg::IDX_MTVAL;
      csr_pkg::MIP_ADDR:           idx = csr_pkg::IDX_MIP;
      csr_pkg::MCYCLE_ADDR:        idx = csr_pkg::IDX_MCYCLE;
      csr_pkg::MCYCLEH_ADDR:       idx = csr_pkg::IDX_MCYCLEH;
      csr_pkg::MINSTRET_ADDR:      idx = csr_pkg::IDX_MINSTRET;
      csr_pkg::MINSTRETH_ADDR:     idx = csr_pkg::IDX_MINSTRETH;
      csr_pkg::MVENDORID_ADDR:     idx = csr_pkg::IDX_MVENDORID;
      csr_pkg::MARCHID_ADDR:       idx = csr_pkg::IDX_MARCHID;
      csr_pkg::MIMPID_ADDR:        idx = csr_pkg::IDX_MIMPID;
      csr_pkg::MHARTID_ADDR:       idx = csr_pkg::IDX_MHARTID;
      csr_pkg::CYCLE_ADDR: begin
        idx      = csr_pkg::IDX_MCYCLE;
        cy_alias = 1'b1;
      end
      csr_pkg::CYCLEH_ADDR: begin
        idx      = csr_pkg::IDX_MCYCLEH;
        cy_alias = 1'b1;
      end
      csr_pkg::INSTRET_ADDR: begin
        idx      = csr_pkg::IDX_MINSTRET;
        ir_alias = 1'b1;
      end
      csr_pkg::INSTRETH_ADDR: begin
        idx      = csr_pkg::IDX_MINSTRETH;
        ir_alias = 1'b1;
      end
      default:                     idx = csr_pkg::IDX_NONE;
    endcase
  end

  assign ro_fault   = (req.addr[11:10] == 2'b11) && !req.read_only;
  assign priv_fault = req.addr[9:8] > priv;
  // mcounteren gates user reads of the counters
  assign gate_fault = (priv == csr_pkg::PRIV_U) &&
                      ((cy_alias && !state.mcounteren[csr_pkg::CNT_CY]) ||
                       (ir_alias && !state.mcounteren[csr_pkg::CNT_IR]));

  assign invalid = op_active &&
                   (ro_fault || priv_fault || gate_fault || idx == csr_pkg::IDX_NONE);

  always_comb begin
    case (req.op)
      csr_pkg::CSR_OP_WRITE: new_value = req.wdata;
      csr_pkg::CSR_OP_SET:   new_value = old | req.wdata;
      csr_pkg::CSR_OP_CLEAR: new_value = old & ~req.wdata;
      default:               new_value = old;
    endcase
  end

  assign wr.en    = op_active && !req.read_only && req.commit && !invalid;
  assign wr.idx   = idx;
  assign wr.value = new_value;

  // Every writable implemented CSR is a machine-level one
  always_comb begin
    assert final (!wr.en || priv == csr_pkg::PRIV_M)
      else $error("csr_access_ctrl: write issued outside machine mode");
  end

endmodule

`default_nettype wire

/* hw/csr_trap_regs.sv */
// Holds the machine trap registers of the CSR file and legalizes each write by its WARL rules
`timescale 1ns/10ps
`default_nettype none

module csr_trap_regs (
  input  logic                     CLK,
  input  logic                     nRST,
  input  csr_pkg::csr_wr_t         wr,
  output csr_pkg::csr_trap_state_t state
);

  csr_pkg::csr_trap_state_t state_next;

  // Only implemented fields survive and a reserved mpp drops to U
  function automatic csr_pkg::csr_data_t legal_mstatus(input csr_pkg::csr_data_t v);
    csr_pkg::csr_data_t r;
    r = v & csr_pkg::MSTATUS_WMASK;
    if (r[12:11] == 2'b10) begin
      r[12:11] = csr_pkg::PRIV_U;
    end
    return r;
  endfunction

  // Modes above vectored fall back to direct and the base is kept
  function automatic csr_pkg::csr_data_t legal_mtvec(input csr_pkg::csr_data_t v);
    csr_pkg::csr_data_t r;
    r = v;
    if (v[1:0] > 2'b01) begin
      r[1:0] = 2'b00;
    end
    return r;
  endfunction

  always_comb begin
    state_next = state;
    if (wr.en) begin
      case (wr.idx)
        csr_pkg::IDX_MSTATUS: begin
          state_next.mstatus = legal_mstatus(wr.value);
        end
        csr_pkg::IDX_MTVEC: begin
          state_next.mtvec = legal_mtvec(wr.value);
        end
        csr_pkg::IDX_MIE: begin
          state_next.mie = wr.value & csr_pkg::MIE_WMASK;
        end
        csr_pkg::IDX_MIP: begin
          state_next.mip = wr.value & csr_pkg::MIE_WMASK; // Same pending layout as mie
        end
        csr_pkg::IDX_MSCRATCH:      state_next.mscratch      = wr.value;
        csr_pkg::IDX_MEPC:          state_next.mepc          = wr.value;
        csr_pkg::IDX_MCAUSE:        state_next.mcause        = wr.value;
        csr_pkg::IDX_MTVAL:         state_next.mtval         = wr.value;
        csr_pkg::IDX_MCOUNTEREN:    state_next.mcounteren    = wr.value;
        csr_pkg::IDX_MCOUNTINHIBIT: state_next.mcountinhibit = wr.value;
        default: begin
          // misa, counters and info registers live elsewhere
        end
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state.mstatus       <= csr_pkg::MSTATUS_RESET;
      state.mie           <= '0;
      state.mtvec         <= '0;
      state.mscratch      <= '0;
      state.mepc          <= '0;
      state.mcause        <= '0;
      state.mtval         <= '0;
      state.mip           <= '0;
      state.mcounteren    <= csr_pkg::MCOUNTEREN_RESET; // User counters open
      state.mcountinhibit <= '0;
    end else begin
      state <= state_next;
    end
  end

  // Reserved vector modes must never be stored
  mtvec_mode_legal: assert property (
    @(posedge CLK) disable iff (!nRST)
    state.mtvec[1:0] <= 2'b01
  ) else $error("csr_trap_regs: mtvec mode above vectored");

endmodule

`default_nettype wire

/* hw/csr_counters.sv */
// 64-bit cycle and retired-instruction counters with inhibit bits and per-half writes
`timescale 1ns/10ps
`default_nettype none

module csr_counters (
  input  logic                CLK,
  input  logic                nRST,
  input  csr_pkg::csr_wr_t    wr,
  input  csr_pkg::csr_data_t  inhibit,
  input  logic                inst_ret,
  output csr_pkg::csr_count_t cycles,
  output csr_pkg::csr_count_t instret
);

  logic cy_lo_wr;
  logic cy_hi_wr;
  logic ir_lo_wr;
  logic ir_hi_wr;

  // Half writes override the increment and keep the other half
  function automatic csr_pkg::csr_count_t count_next(
    input csr_pkg::csr_count_t cur,
    input logic                inc,
    input logic                lo_wr,
    input logic                hi_wr,
    input csr_pkg::csr_data_t  value
  );
    csr_pkg::csr_count_t r;
    r = cur + csr_pkg::csr_count_t'(inc);
    if (lo_wr) begin
      r = {cur[63:32], value};
    end else if (hi_wr) begin
      r = {value, cur[31:0]};
    end
    return r;
  endfunction

  assign cy_lo_wr = wr.en && wr.idx == csr_pkg::IDX_MCYCLE;
  assign cy_hi_wr = wr.en && wr.idx == csr_pkg::IDX_MCYCLEH;
  assign ir_lo_wr = wr.en && wr.idx == csr_pkg::IDX_MINSTRET;
  assign ir_hi_wr = wr.en && wr.idx == csr_pkg::IDX_MINSTRETH;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycles  <= '0;
      instret <= '0;
    end else begin
      cycles  <= count_next(cycles, !inhibit[csr_pkg::CNT_CY], cy_lo_wr, cy_hi_wr, wr.value);
      instret <= count_next(instret, inst_ret && !inhibit[csr_pkg::CNT_IR],
                            ir_lo_wr, ir_hi_wr, wr.value);
    end
  end

  // Index encoding gives each half its own code
  one_half_per_write: assert property (
    @(posedge CLK) disable iff (!nRST)
    $onehot0({cy_lo_wr, cy_hi_wr, ir_lo_wr, ir_hi_wr})
  ) else $error("csr_counters: write names two counter halves");

endmodule

`default_nettype wire

/* hw/csr_read_mux.sv */
// Read-side selection of the current CSR value by internal index, constant info registers included
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux #(
  parameter int unsigned HART_ID = 0
) (
  input  csr_pkg::csr_index_t      idx,
  input  csr_pkg::csr_trap_state_t state,
  input  csr_pkg::csr_count_t      cycles,
  input  csr_pkg::csr_count_t      instret,
  output csr_pkg::csr_data_t       old
);

  localparam csr_pkg::csr_data_t HART_WORD = csr_pkg::csr_data_t'(HART_ID);

  always_comb begin
    case (idx)
      // Trap setup
      csr_pkg::IDX_MSTATUS:       old = state.mstatus;
      csr_pkg::IDX_MISA:          old = csr_pkg::MISA_VALUE;
      csr_pkg::IDX_MIE:           old = state.mie;
      csr_pkg::IDX_MTVEC:         old = state.mtvec;
      csr_pkg::IDX_MCOUNTEREN:    old = state.mcounteren;
      csr_pkg::IDX_MCOUNTINHIBIT: old = state.mcountinhibit;

      // Trap handling
      csr_pkg::IDX_MSCRATCH:      old = state.mscratch;
      csr_pkg::IDX_MEPC:          old = state.mepc;
      csr_pkg::IDX_MCAUSE:        old = state.mcause;
      csr_pkg::IDX_MTVAL:         old = state.mtval;
      csr_pkg::IDX_MIP:           old = state.mip;

      // Counter halves
      csr_pkg::IDX_MCYCLE:        old = cycles[31:0];
      csr_pkg::IDX_MCYCLEH:       old = cycles[63:32];
      csr_pkg::IDX_MINSTRET:      old = instret[31:0];
      csr_pkg::IDX_MINSTRETH:     old = instret[63:32];

      // Fixed identification
      csr_pkg::IDX_MVENDORID:     old = '0; // Non-commercial
      csr_pkg::IDX_MARCHID:       old = '0;
      csr_pkg::IDX_MIMPID:        old = '0;
      csr_pkg::IDX_MHARTID:       old = HART_WORD;

      default:                    old = '0; // Unmapped reads as zero
    endcase
  end

endmodule

`default_nettype wire

/* hw/csr_file_top.sv */
// Machine-mode CSR file top level, joins access control, trap registers, counters and read mux
`timescale 1ns/10ps
`default_nettype none

module csr_file_top #(
  parameter int unsigned HART_ID = 0
) (
  input  logic               CLK,
  input  logic               nRST,
  input  csr_pkg::csr_req_t  req,
  input  csr_pkg::csr_priv_t priv,
  input  logic               inst_ret,
  output csr_pkg::csr_rsp_t  rsp
);

  csr_pkg::csr_index_t      idx;
  csr_pkg::csr_data_t       old;
  csr_pkg::csr_wr_t         wr;
  csr_pkg::csr_trap_state_t state;
  csr_pkg::csr_count_t      cycles;
  csr_pkg::csr_count_t      instret;
  logic                     invalid;

  csr_access_ctrl u_access_ctrl (
    .req     (req),
    .priv    (priv),
    .old     (old),
    .state   (state),
    .idx     (idx),
    .wr      (wr),
    .invalid (invalid)
  );

  csr_trap_regs u_trap_regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wr    (wr),
    .state (state)
  );

  csr_counters u_counters (
    .CLK      (CLK),
    .nRST     (nRST),
    .wr       (wr),
    .inhibit  (state.mcountinhibit),
    .inst_ret (inst_ret),
    .cycles   (cycles),
    .instret  (instret)
  );

  csr_read_mux #(
    .HART_ID (HART_ID)
  ) u_read_mux (
    .idx     (idx),
    .state   (state),
    .cycles  (cycles),
    .instret (instret),
    .old     (old)
  );

  // Response is the pre-access value, same cycle
  assign rsp.rdata   = old;
  assign rsp.invalid = invalid;

endmodule

`default_nettype wire

/* verification/tb_csr_file.sv */
// Testbench that drives CSR accesses into the CSR file and checks each response by assertion
`timescale 1ns/10ps
`default_nettype none

module tb_csr_file;

  // Legal field layouts of mstatus and mie
  localparam logic [31:0] MST_LEGAL = (32'd1 << 3) | (32'd1 << 7) | (32'd3 << 11) |
                                      (32'd1 << 17) | (32'd1 << 21);
  localparam logic [31:0] MIE_LEGAL = (32'd1 << 3) | (32'd1 << 7) | (32'd1 << 11);

  logic               CLK;
  logic               nRST;
  csr_pkg::csr_req_t  req;
  csr_pkg::csr_priv_t priv;
  logic               inst_ret;
  csr_pkg::csr_rsp_t  rsp;

  integer      seed;
  integer      rdata_errors;
  integer      invalid_errors;
  string       test_name;
  logic        chk_rdata;
  logic [31:0] exp_rdata;
  logic        exp_invalid;
  logic [31:0] model [0:4095]; // Reference registers by address
  logic [63:0] ref_cycles;
  logic [63:0] ref_instret;
  logic [31:0] ref_inhibit;
  logic        ref_wr;

  csr_file_top #(
    .HART_ID (5)
  ) u_csr_file_top (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .priv     (priv),
    .inst_ret (inst_ret),
    .rsp      (rsp)
  );

  always #2 CLK = ~CLK;

  assign ref_wr = req.op != csr_pkg::CSR_OP_NONE && !req.read_only && req.commit && !exp_invalid;

  // Counter reference where a committed half write replaces the increment
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ref_cycles  <= '0;
      ref_instret <= '0;
      ref_inhibit <= '0;
    end else begin
      if (ref_wr && req.addr == csr_pkg::MCYCLEH_ADDR) begin
        ref_cycles <= {req.wdata, ref_cycles[31:0]};
      end else if (!ref_inhibit[0]) begin
        ref_cycles <= ref_cycles + 64'd1;
      end
      if (inst_ret && !ref_inhibit[2]) begin
        ref_instret <= ref_instret + 64'd1;
      end
      if (ref_wr && req.addr == csr_pkg::MCOUNTINHIBIT_ADDR) begin
        ref_inhibit <= req.wdata;
      end
    end
  end

  function automatic logic is_implemented(input logic [11:0] a);
    case (a)
      csr_pkg::MSTATUS_ADDR, csr_pkg::MISA_ADDR, csr_pkg::MIE_ADDR, csr_pkg::MTVEC_ADDR,
      csr_pkg::MCOUNTEREN_ADDR, csr_pkg::MCOUNTINHIBIT_ADDR, csr_pkg::MSCRATCH_ADDR,
      csr_pkg::MEPC_ADDR, csr_pkg::MCAUSE_ADDR, csr_pkg::MTVAL_ADDR, csr_pkg::MIP_ADDR,
      csr_pkg::MCYCLE_ADDR, csr_pkg::MINSTRET_ADDR, csr_pkg::MCYCLEH_ADDR,
      csr_pkg::MINSTRETH_ADDR, csr_pkg::CYCLE_ADDR, csr_pkg::INSTRET_ADDR,
      csr_pkg::CYCLEH_ADDR, csr_pkg::INSTRETH_ADDR, csr_pkg::MVENDORID_ADDR,
      csr_pkg::MARCHID_ADDR, csr_pkg::MIMPID_ADDR, csr_pkg::MHARTID_ADDR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // The four access rules
  function automatic logic expected_invalid(input csr_pkg::csr_op_t op, input logic ro,
                                            input logic [11:0] a);
    logic cy;
    logic ir;
    cy = a == csr_pkg::CYCLE_ADDR || a == csr_pkg::CYCLEH_ADDR;
    ir = a == csr_pkg::INSTRET_ADDR || a == csr_pkg::INSTRETH_ADDR;
    if (op == csr_pkg::CSR_OP_NONE) begin
      return 1'b0;
    end
    return (a[11:10] == 2'b11 && !ro) || (a[9:8] > priv) || !is_implemented(a) ||
           (priv == csr_pkg::PRIV_U && ((cy && !model[csr_pkg::MCOUNTEREN_ADDR][0]) ||
                                        (ir && !model[csr_pkg::MCOUNTEREN_ADDR][2])));
  endfunction

  function automatic logic [31:0] expected_old(input logic [11:0] a);
    case (a)
      csr_pkg::MCYCLE_ADDR, csr_pkg::CYCLE_ADDR:       return ref_cycles[31:0];
      csr_pkg::MCYCLEH_ADDR, csr_pkg::CYCLEH_ADDR:     return ref_cycles[63:32];
      csr_pkg::MINSTRET_ADDR, csr_pkg::INSTRET_ADDR:   return ref_instret[31:0];
      csr_pkg::MINSTRETH_ADDR, csr_pkg::INSTRETH_ADDR: return ref_instret[63:32];
      csr_pkg::MISA_ADDR:                              return csr_pkg::MISA_VALUE;
      csr_pkg::MHARTID_ADDR:                           return 32'd5;
      default:                                         return model[a];
    endcase
  endfunction

  // WARL rules applied to a written value
  function automatic logic [31:0] legal_value(input logic [11:0] a, input logic [31:0] v);
    logic [31:0] r;
    r = v;
    case (a)
      csr_pkg::MSTATUS_ADDR: begin
        r = v & MST_LEGAL;
        if (r[12:11] == 2'b10) begin
          r[12:11] = 2'b00; // Reserved mpp reads as U
        end
      end
      csr_pkg::MIE_ADDR, csr_pkg::MIP_ADDR: r = v & MIE_LEGAL;
      csr_pkg::MTVEC_ADDR: begin
        if (v[1:0] > 2'b01) begin
          r[1:0] = 2'b00;
        end
      end
      default: r = v;
    endcase
    return r;
  endfunction

  // One access per cycle checked at the next rising edge
  task automatic access_csr(input string name, input csr_pkg::csr_op_t op, input logic ro,
                            input logic [11:0] a, input logic [31:0] wdata);
    logic [31:0] old;
    logic [31:0] nxt;
    @(negedge CLK);
    old = expected_old(a);
    case (op)
      csr_pkg::CSR_OP_WRITE: nxt = wdata;
      csr_pkg::CSR_OP_SET:   nxt = old | wdata;
      csr_pkg::CSR_OP_CLEAR: nxt = old & ~wdata;
      default:               nxt = old;
    endcase
    test_name     = name;
    req.op        = op;
    req.read_only = ro;
    req.commit    = 1'b1;
    req.addr      = a;
    req.wdata     = wdata;
    exp_rdata     = old;
    exp_invalid   = expected_invalid(op, ro, a);
    chk_rdata     = 1'b1;
    if (op != csr_pkg::CSR_OP_NONE && !ro && !exp_invalid) begin
      model[a] = legal_value(a, nxt);
    end
  endtask

  // Write the core does not retire, the register keeps its value
  task automatic uncommitted_write(input string name, input logic [11:0] a,
                                   input logic [31:0] wdata);
    @(negedge CLK);
    test_name     = name;
    req.op        = csr_pkg::CSR_OP_WRITE;
    req.read_only = 1'b0;
    req.commit    = 1'b0;
    req.addr      = a;
    req.wdata     = wdata;
    exp_rdata     = expected_old(a);
    exp_invalid   = expected_invalid(csr_pkg::CSR_OP_WRITE, 1'b0, a);
    chk_rdata     = 1'b1;
  endtask

  task automatic read_csr(input string name, input logic [11:0] a);
    access_csr(name, csr_pkg::CSR_OP_SET, 1'b1, a, 32'd0);
  endtask

  // Random address and data on the bus without an access
  task automatic idle_cycle();
    logic [31:0] d;
    @(negedge CLK);
    d             = $random(seed);
    test_name     = "idle";
    req.op        = csr_pkg::CSR_OP_NONE;
    req.read_only = d[12];
    req.addr      = d[11:0];
    req.wdata     = d;
    chk_rdata     = 1'b0;
    exp_invalid   = 1'b0;
  endtask

  task automatic set_priv(input csr_pkg::csr_priv_t p);
    idle_cycle();
    priv = p;
  endtask

  rdata_matches: assert property (
    @(posedge CLK) disable iff (!nRST)
    chk_rdata |-> rsp.rdata == exp_rdata
  ) else begin
    rdata_errors = rdata_errors + 1;
    $display("MISMATCH %s rdata expected %h actual %h", test_name, exp_rdata,
             $sampled(rsp.rdata));
  end

  invalid_matches: assert property (
    @(posedge CLK) disable iff (!nRST)
    rsp.invalid == exp_invalid
  ) else begin
    invalid_errors = invalid_errors + 1;
    $display("MISMATCH %s invalid expected %b actual %b", test_name, exp_invalid,
             $sampled(rsp.invalid));
  end

  none_never_invalid: assert property (
    @(posedge CLK) disable iff (!nRST)
    req.op == csr_pkg::CSR_OP_NONE |-> !rsp.invalid
  ) else begin
    invalid_errors = invalid_errors + 1;
    $display("Invalid was raised without any access in test %s", test_name);
  end

  // Watchdog over the whole run
  initial begin
    integer n;
    for (n = 0; n < 2000; n = n + 1) begin
      @(posedge CLK);
    end
    $display("Timeout: the stimulus did not finish within 2000 clock cycles");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [11:0] a;
    integer      i;
    CLK            = 1'b0;
    nRST           = 1'b1;
    req            = '0;
    priv           = csr_pkg::PRIV_M;
    inst_ret       = 1'b0;
    seed           = 32'hf57;
    rdata_errors   = 0;
    invalid_errors = 0;
    test_name      = "reset";
    chk_rdata      = 1'b0;
    exp_rdata      = '0;
    exp_invalid    = 1'b0;
    foreach (model[k]) begin
      model[k] = '0;
    end
    model[csr_pkg::MSTATUS_ADDR]    = 32'h0020_0000; // tw set and mpp U
    model[csr_pkg::MCOUNTEREN_ADDR] = 32'hFFFF_FFFF;
    @(negedge CLK);
    nRST = 1'b0;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;

    read_csr("reset mstatus", csr_pkg::MSTATUS_ADDR);
    read_csr("reset mcounteren", csr_pkg::MCOUNTEREN_ADDR);
    read_csr("reset mhartid", csr_pkg::MHARTID_ADDR);
    read_csr("reset misa", csr_pkg::MISA_ADDR);
    read_csr("reset mvendorid", csr_pkg::MVENDORID_ADDR);

    for (i = 0; i < 3; i = i + 1) begin
      a = (i == 0) ? csr_pkg::MSCRATCH_ADDR :
          ((i == 1) ? csr_pkg::MEPC_ADDR : csr_pkg::MCAUSE_ADDR);
      access_csr("data write", csr_pkg::CSR_OP_WRITE, 1'b0, a, $random(seed));
      access_csr("data set", csr_pkg::CSR_OP_SET, 1'b0, a, $random(seed));
      access_csr("data clear", csr_pkg::CSR_OP_CLEAR, 1'b0, a, $random(seed));
      access_csr("read-only set", csr_pkg::CSR_OP_SET, 1'b1, a, $random(seed));
      access_csr("read-only clear", csr_pkg::CSR_OP_CLEAR, 1'b1, a, $random(seed));
      uncommitted_write("uncommitted write", a, $random(seed));
      read_csr("data readback", a);
    end

    // Random WARL values first and then the reserved encodings
    for (i = 0; i < 8; i = i + 1) begin
      access_csr("warl mtvec", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MTVEC_ADDR, $random(seed));
      read_csr("warl mtvec readback", csr_pkg::MTVEC_ADDR);
      access_csr("warl mstatus", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MSTATUS_ADDR, $random(seed));
      read_csr("warl mstatus readback", csr_pkg::MSTATUS_ADDR);
      access_csr("warl mie", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MIE_ADDR, $random(seed));
      read_csr("warl mie readback", csr_pkg::MIE_ADDR);
    end
    access_csr("mpp reserved", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MSTATUS_ADDR, 32'h0000_1088);
    read_csr("mpp reserved readback", csr_pkg::MSTATUS_ADDR);
    access_csr("mtvec mode 3", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MTVEC_ADDR, 32'h8000_0103);
    read_csr("mtvec mode readback", csr_pkg::MTVEC_ADDR);

    set_priv(csr_pkg::PRIV_U);
    access_csr("user mscratch write", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MSCRATCH_ADDR,
               $random(seed));
    set_priv(csr_pkg::PRIV_M);
    read_csr("mscratch kept", csr_pkg::MSCRATCH_ADDR);
    access_csr("mhartid write", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MHARTID_ADDR, $random(seed));
    access_csr("unimplemented read", csr_pkg::CSR_OP_SET, 1'b1, 12'h7C0, 32'd0);
    access_csr("unimplemented write", csr_pkg::CSR_OP_WRITE, 1'b0, 12'h3A0, $random(seed));
    repeat (8) idle_cycle();

    read_csr("mcycle step", csr_pkg::MCYCLE_ADDR);
    read_csr("mcycle step", csr_pkg::MCYCLE_ADDR);
    access_csr("mcycleh write", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MCYCLEH_ADDR, $random(seed));
    read_csr("mcycleh readback", csr_pkg::MCYCLEH_ADDR);
    access_csr("inhibit mcycle", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MCOUNTINHIBIT_ADDR, 32'h1);
    repeat (3) read_csr("mcycle frozen", csr_pkg::MCYCLE_ADDR);
    read_csr("minstret before", csr_pkg::MINSTRET_ADDR);
    for (i = 0; i < 20; i = i + 1) begin
      idle_cycle();
      inst_ret = req.wdata[20]; // Random retire pattern
    end
    idle_cycle();
    inst_ret = 1'b0;
    read_csr("minstret after", csr_pkg::MINSTRET_ADDR);

    set_priv(csr_pkg::PRIV_U);
    read_csr("user cycle allowed", csr_pkg::CYCLE_ADDR);
    set_priv(csr_pkg::PRIV_M);
    access_csr("mcounteren clear", csr_pkg::CSR_OP_WRITE, 1'b0, csr_pkg::MCOUNTEREN_ADDR, 32'd0);
    set_priv(csr_pkg::PRIV_U);
    read_csr("user cycle gated", csr_pkg::CYCLE_ADDR);
    read_csr("user instret gated", csr_pkg::INSTRET_ADDR);
    set_priv(csr_pkg::PRIV_M);
    idle_cycle();
    @(negedge CLK);

    $display("Errors: rdata %0d, invalid %0d, total %0d", rdata_errors, invalid_errors,
             rdata_errors + invalid_errors);
    if (rdata_errors + invalid_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hw/csr_pkg.sv
hw/csr_access_ctrl.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/csr_read_mux.sv
hw/csr_file_top.sv
verification/tb_csr_file.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CSR file testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_csr_file \
  -Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vtb_csr_file" | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
